// File: design/window_monitor_defines.svh
// Widths and reset values shared by all blocks; COMPARE_STAGES must be 2 or more and PERSIST_W at least 1.
`ifndef WINDOW_MONITOR_DEFINES_SVH
`define WINDOW_MONITOR_DEFINES_SVH

// Sample and limit width.
`define DATA_W 8

// Register stages from the sample input to zone_valid.
`define COMPARE_STAGES 2

// Width of the persistence setting and of the run counter.
`define PERSIST_W 4

// Width of the outlier and raise counters.
`define COUNT_W 16

// Configuration after reset.
`define RESET_LOWER 8'h40
`define RESET_UPPER 8'hC0
`define RESET_PERSIST 3

`endif

// File: design/window_monitor_pkg.sv
// Type definitions only; every enum is 2 bits wide and the encodings are fixed.
package window_monitor_pkg;

    // Configuration opcodes carried on cfg_op.
    typedef enum logic [1:0] {
        OP_SET_LOWER    = 2'b00,
        OP_SET_UPPER    = 2'b01,
        OP_SET_PERSIST  = 2'b10,
        OP_CLEAR_COUNTS = 2'b11
    } cfg_op_t;

    // Classification of a sample against the window.
    typedef enum logic [1:0] {
        ZONE_BELOW  = 2'b00,
        ZONE_INSIDE = 2'b01,
        ZONE_ABOVE  = 2'b10
    } zone_t;

    // States of the alarm filter.
    typedef enum logic [1:0] {
        ST_NORMAL  = 2'b00,
        ST_ALARM   = 2'b01,
        ST_RECOVER = 2'b10
    } alarm_state_t;

endpackage

// File: design/limit_config.sv
// Writes take effect on the strobe edge; limits are not reordered, and lower above upper empties the window.
`timescale 1ns/1ps
`include "window_monitor_defines.svh"

module limit_config
    import window_monitor_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cfg_write,
    input  cfg_op_t               cfg_op,
    input  logic [`DATA_W-1:0]    cfg_data,
    output logic [`DATA_W-1:0]    lower_limit,
    output logic [`DATA_W-1:0]    upper_limit,
    output logic [`PERSIST_W-1:0] persist,
    output logic                  clear_counts
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lower_limit <= `RESET_LOWER;
            upper_limit <= `RESET_UPPER;
            persist     <= `PERSIST_W'(`RESET_PERSIST);
        end else if (cfg_write) begin
            case (cfg_op)
                OP_SET_LOWER: begin
                    lower_limit <= cfg_data;
                end
                OP_SET_UPPER: begin
                    upper_limit <= cfg_data;
                end
                OP_SET_PERSIST: begin
                    persist <= cfg_data[`PERSIST_W-1:0]; // Upper data bits are ignored.
                end
                OP_CLEAR_COUNTS: begin
                    // Handled by the pulse register below.
                end
                default: begin
                end
            endcase
        end
    end

    // One-cycle clear pulse, high in the cycle after the write edge.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clear_counts <= 1'b0;
        end else begin
            clear_counts <= cfg_write && (cfg_op == OP_CLEAR_COUNTS);
        end
    end

endmodule

// File: design/range_compare.sv
// STAGES must be 2 or more; each sample keeps the limits it entered with, and zone is only meaningful with zone_valid.
`timescale 1ns/1ps
`include "window_monitor_defines.svh"

module range_compare
    import window_monitor_pkg::*;
#(
    parameter int unsigned STAGES = `COMPARE_STAGES
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               sample_valid,
    input  logic [`DATA_W-1:0] sample_data,
    input  logic [`DATA_W-1:0] lower_limit,
    input  logic [`DATA_W-1:0] upper_limit,
    output logic               zone_valid,
    output zone_t              zone
);

    logic               s1_valid;
    logic [`DATA_W-1:0] s1_data;
    logic [`DATA_W-1:0] s1_lower;
    logic [`DATA_W-1:0] s1_upper;
    logic [`DATA_W:0]   diff_lower;
    logic [`DATA_W:0]   diff_upper;
    logic               not_below;
    logic               not_above;
    zone_t              s1_zone;
    logic [STAGES-2:0]  vld_pipe;
    zone_t              zone_pipe [STAGES-1];

    // Stage one holds the sample and its limits until the next valid sample.
    always_ff @(posedge clk) begin
        if (sample_valid) begin
            s1_data  <= sample_data;
            s1_lower <= lower_limit;
            s1_upper <= upper_limit;
        end
    end

    // Subtract with carry in; the carry out is set when no borrow occurs.
    assign diff_lower = {1'b0, s1_data} + {1'b0, ~s1_lower} + 1'b1;
    assign diff_upper = {1'b0, s1_upper} + {1'b0, ~s1_data} + 1'b1;
    assign not_below  = diff_lower[`DATA_W];
    assign not_above  = diff_upper[`DATA_W];

    always_comb begin
        if (!not_below) begin
            s1_zone = ZONE_BELOW;
        end else if (!not_above) begin
            s1_zone = ZONE_ABOVE;
        end else begin
            s1_zone = ZONE_INSIDE;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            vld_pipe <= '0;
        end else begin
            s1_valid    <= sample_valid;
            vld_pipe[0] <= s1_valid;
            for (int i = 1; i < STAGES - 1; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        zone_pipe[0] <= s1_zone;
        for (int i = 1; i < STAGES - 1; i++) begin
            zone_pipe[i] <= zone_pipe[i-1];
        end
    end

    assign zone_valid = vld_pipe[STAGES-2];
    assign zone       = zone_pipe[STAGES-2];

endmodule

// File: design/persistence_filter.sv
// A persist of zero acts as one; the run counter saturates and only moves on zone_valid cycles.
`timescale 1ns/1ps
`include "window_monitor_defines.svh"

module persistence_filter
    import window_monitor_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  zone_valid,
    input  zone_t                 zone,
    input  logic [`PERSIST_W-1:0] persist,
    output logic                  alarm,
    output logic                  alarm_raise
);

    alarm_state_t          state;
    alarm_state_t          state_next;
    logic [`PERSIST_W-1:0] run;
    logic [`PERSIST_W-1:0] run_next;
    logic [`PERSIST_W-1:0] run_inc;
    logic [`PERSIST_W-1:0] threshold;
    logic                  outlier;

    assign threshold = (persist == '0) ? `PERSIST_W'(1) : persist;
    assign run_inc   = (run == '1) ? run : run + 1'b1; // Saturates at all ones.
    assign outlier   = (zone != ZONE_INSIDE);

    always_comb begin
        state_next = state;
        run_next   = run;
        if (zone_valid) begin
            case (state)
                ST_NORMAL: begin
                    if (!outlier) begin
                        run_next = '0;
                    end else if (run_inc >= threshold) begin
                        state_next = ST_ALARM;
                        run_next   = '0;
                    end else begin
                        run_next = run_inc;
                    end
                end
                ST_ALARM: begin
                    if (!outlier) begin
                        // The first inside sample already counts toward recovery.
                        if (threshold == `PERSIST_W'(1)) begin
                            state_next = ST_NORMAL;
                            run_next   = '0;
                        end else begin
                            state_next = ST_RECOVER;
                            run_next   = `PERSIST_W'(1);
                        end
                    end
                end
                ST_RECOVER: begin
                    if (outlier) begin
                        state_next = ST_ALARM; // Alarm stays high, no new raise.
                        run_next   = '0;
                    end else if (run_inc >= threshold) begin
                        state_next = ST_NORMAL;
                        run_next   = '0;
                    end else begin
                        run_next = run_inc;
                    end
                end
                default: begin
                    state_next = ST_NORMAL;
                    run_next   = '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_NORMAL;
            run         <= '0;
            alarm_raise <= 1'b0;
        end else begin
            state       <= state_next;
            run         <= run_next;
            alarm_raise <= (state == ST_NORMAL) && (state_next == ST_ALARM);
        end
    end

    assign alarm = (state != ST_NORMAL);

endmodule

// File: design/excursion_counter.sv
// Both counters stick at their maximum; a clear wins over an increment in the same cycle.
`timescale 1ns/1ps
`include "window_monitor_defines.svh"

module excursion_counter
    import window_monitor_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                zone_valid,
    input  zone_t               zone,
    input  logic                alarm_raise,
    input  logic                clear_counts,
    output logic [`COUNT_W-1:0] outlier_count,
    output logic [`COUNT_W-1:0] raise_count
);

    logic outlier_hit;

    // Adds one when enabled, but never wraps past all ones.
    function automatic logic [`COUNT_W-1:0] sat_inc(
        input logic [`COUNT_W-1:0] count,
        input logic                enable
    );
        logic [`COUNT_W-1:0] result;
        result = count;
        if (enable && (count != '1)) begin
            result = count + 1'b1;
        end
        return result;
    endfunction

    assign outlier_hit = zone_valid && (zone != ZONE_INSIDE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outlier_count <= '0;
            raise_count   <= '0;
        end else if (clear_counts) begin
            outlier_count <= '0;
            raise_count   <= '0;
        end else begin
            outlier_count <= sat_inc(outlier_count, outlier_hit);
            raise_count   <= sat_inc(raise_count, alarm_raise);
        end
    end

endmodule

// File: design/window_monitor_top.sv
// Single channel, no back-pressure; every valid sample is classified and counted.
`timescale 1ns/1ps
`include "window_monitor_defines.svh"

module window_monitor_top
    import window_monitor_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sample_valid,
    input  logic [`DATA_W-1:0]  sample_data,
    input  logic                cfg_write,
    input  cfg_op_t             cfg_op,
    input  logic [`DATA_W-1:0]  cfg_data,
    output logic                zone_valid,
    output zone_t               zone,
    output logic                alarm,
    output logic [`COUNT_W-1:0] outlier_count,
    output logic [`COUNT_W-1:0] raise_count
);

    logic [`DATA_W-1:0]    lower_limit;
    logic [`DATA_W-1:0]    upper_limit;
    logic [`PERSIST_W-1:0] persist;
    logic                  clear_counts;
    logic                  alarm_raise;

    limit_config u_limit_config (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_write    (cfg_write),
        .cfg_op       (cfg_op),
        .cfg_data     (cfg_data),
        .lower_limit  (lower_limit),
        .upper_limit  (upper_limit),
        .persist      (persist),
        .clear_counts (clear_counts)
    );

    range_compare #(
        .STAGES (`COMPARE_STAGES)
    ) u_range_compare (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .lower_limit  (lower_limit),
        .upper_limit  (upper_limit),
        .zone_valid   (zone_valid),
        .zone         (zone)
    );

    persistence_filter u_persistence_filter (
        .clk         (clk),
        .rst_n       (rst_n),
        .zone_valid  (zone_valid),
        .zone        (zone),
        .persist     (persist),
        .alarm       (alarm),
        .alarm_raise (alarm_raise)
    );

    excursion_counter u_excursion_counter (
        .clk           (clk),
        .rst_n         (rst_n),
        .zone_valid    (zone_valid),
        .zone          (zone),
        .alarm_raise   (alarm_raise),
        .clear_counts  (clear_counts),
        .outlier_count (outlier_count),
        .raise_count   (raise_count)
    );

endmodule

// File: verification/window_monitor_checker.sv
// Samples DUT pins at the falling edge and expects each zone COMPARE_STAGES cycles after its sample.
`timescale 1ns/1ps
`include "window_monitor_defines.svh"

module window_monitor_checker
    import window_monitor_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sample_valid,
    input  logic [`DATA_W-1:0]  sample_data,
    input  logic                table_valid,
    input  zone_t               table_zone,
    input  logic                cfg_write,
    input  cfg_op_t             cfg_op,
    input  logic [`DATA_W-1:0]  cfg_data,
    input  logic                zone_valid,
    input  zone_t               zone,
    input  logic                alarm,
    input  logic [`COUNT_W-1:0] outlier_count,
    input  logic [`COUNT_W-1:0] raise_count,
    output int                  mismatch_count,
    output int                  timeout_count,
    output int                  pending
);

    zone_t                 zone_q [$];
    int                    stamp_q [$];
    logic                  table_valid_q [$];
    zone_t                 table_zone_q [$];
    logic [`DATA_W-1:0]    m_lower;
    logic [`DATA_W-1:0]    m_upper;
    logic [`PERSIST_W-1:0] m_persist;
    logic                  m_clear;
    logic                  m_raise;
    alarm_state_t          m_state;
    int                    m_run;
    logic [`COUNT_W-1:0]   m_outliers;
    logic [`COUNT_W-1:0]   m_raises;
    int                    cycle;
    int                    stamp;
    logic                  got_zone;
    zone_t                 exp_zone;
    logic                  listed;
    zone_t                 listed_zone;

    // Both limits are inclusive.
    function automatic zone_t classify(
        input logic [`DATA_W-1:0] value,
        input logic [`DATA_W-1:0] lower,
        input logic [`DATA_W-1:0] upper
    );
        if (value < lower) begin
            return ZONE_BELOW;
        end
        if (value > upper) begin
            return ZONE_ABOVE;
        end
        return ZONE_INSIDE;
    endfunction

    task automatic compare_field(input string field, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Fail at %0d ns: %s expected %0h, got %0h",
                     $time, field, expected, actual);
        end
    endtask

    task automatic check_zone();
        got_zone = 1'b0;
        if (zone_valid) begin
            if (zone_q.size() == 0) begin
                mismatch_count++;
                $display("Unexpected zone_valid at %0d ns with no sample in flight", $time);
            end else begin
                exp_zone    = zone_q.pop_front();
                stamp       = stamp_q.pop_front();
                listed      = table_valid_q.pop_front();
                listed_zone = table_zone_q.pop_front();
                got_zone    = 1'b1;
                compare_field("zone", exp_zone, zone);
                if (listed) begin
                    compare_field("table zone", listed_zone, zone);
                end
                compare_field("zone latency", `COMPARE_STAGES, cycle - stamp);
            end
        end else if (stamp_q.size() > 0 && cycle - stamp_q[0] > `COMPARE_STAGES + 5) begin
            timeout_count++;
            $display("Timeout at %0d ns: a sample never produced zone_valid", $time);
            zone_q.delete(0);
            stamp_q.delete(0);
            table_valid_q.delete(0);
            table_zone_q.delete(0);
        end
    endtask

    task automatic step_filter(input zone_t z);
        int thr;
        thr = (m_persist == 0) ? 1 : m_persist; // Zero persistence behaves as one.
        if (z == ZONE_INSIDE) begin
            if (m_state == ST_NORMAL) begin
                m_run = 0;
            end else begin
                m_run   = (m_state == ST_ALARM) ? 1 : m_run + 1;
                m_state = (m_run >= thr) ? ST_NORMAL : ST_RECOVER;
                m_run   = (m_state == ST_NORMAL) ? 0 : m_run;
            end
        end else if (m_state == ST_NORMAL) begin
            m_run++;
            if (m_run >= thr) begin
                m_state = ST_ALARM;
                m_run   = 0;
                m_raise = 1'b1;
            end
        end else begin
            m_state = ST_ALARM; // A relapse during recovery raises nothing new.
            m_run   = 0;
        end
    endtask

    // Moves the model across the next rising edge with config changes applied last.
    task automatic advance_model();
        if (m_clear) begin
            m_outliers = '0;
            m_raises   = '0;
        end else begin
            if (got_zone && exp_zone != ZONE_INSIDE && m_outliers != '1) begin
                m_outliers++;
            end
            if (m_raise && m_raises != '1) begin
                m_raises++;
            end
        end
        m_raise = 1'b0;
        if (got_zone) begin
            step_filter(exp_zone);
        end
        m_clear = cfg_write && (cfg_op == OP_CLEAR_COUNTS);
        if (sample_valid) begin
            zone_q.push_back(classify(sample_data, m_lower, m_upper));
            stamp_q.push_back(cycle);
            table_valid_q.push_back(table_valid);
            table_zone_q.push_back(table_zone);
        end
        if (cfg_write && cfg_op == OP_SET_LOWER) begin
            m_lower = cfg_data;
        end else if (cfg_write && cfg_op == OP_SET_UPPER) begin
            m_upper = cfg_data;
        end else if (cfg_write && cfg_op == OP_SET_PERSIST) begin
            m_persist = cfg_data[`PERSIST_W-1:0];
        end
    endtask

    always @(negedge clk) begin
        cycle++;
        if (!rst_n) begin
            m_lower    = `RESET_LOWER;
            m_upper    = `RESET_UPPER;
            m_persist  = `PERSIST_W'(`RESET_PERSIST);
            m_clear    = 1'b0;
            m_raise    = 1'b0;
            m_state    = ST_NORMAL;
            m_run      = 0;
            m_outliers = '0;
            m_raises   = '0;
            zone_q.delete();
            stamp_q.delete();
            table_valid_q.delete();
            table_zone_q.delete();
        end else begin
            compare_field("alarm", m_state != ST_NORMAL, alarm);
            compare_field("outlier_count", m_outliers, outlier_count);
            compare_field("raise_count", m_raises, raise_count);
            check_zone();
            advance_model();
        end
        pending = zone_q.size();
    end

endmodule

// File: verification/window_monitor_tb.sv
// Inputs change 1 ns after the rising edge; the random phase repeats from a fixed seed.
`timescale 1ns/1ps
`include "window_monitor_defines.svh"

module window_monitor_tb
    import window_monitor_pkg::*;
();

    localparam logic KIND_SAMPLE = 1'b0;
    localparam logic KIND_CONFIG = 1'b1;

    typedef struct packed {
        logic               kind;
        logic [`DATA_W-1:0] data;
        cfg_op_t            op;
        zone_t              zone;
        logic [3:0]         gap;
    } row_t;

    logic                clk;
    logic                rst_n;
    logic                sample_valid;
    logic [`DATA_W-1:0]  sample_data;
    logic                table_valid;
    zone_t               table_zone;
    logic                cfg_write;
    cfg_op_t             cfg_op;
    logic [`DATA_W-1:0]  cfg_data;
    logic                zone_valid;
    zone_t               zone;
    logic                alarm;
    logic [`COUNT_W-1:0] outlier_count;
    logic [`COUNT_W-1:0] raise_count;
    int                  mismatch_count;
    int                  timeout_count;
    int                  pending;
    int                  drain_errors;
    logic [31:0]         rand_state;
    row_t                rows [$];

    window_monitor_top DUT (.*);

    window_monitor_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic add_row(input logic kind, input logic [`DATA_W-1:0] data,
                           input cfg_op_t op, input zone_t expected, input int gap);
        rows.push_back(row_t'{kind, data, op, expected, gap[3:0]});
    endtask

    task automatic drive_idle();
        @(posedge clk);
        #1;
        sample_valid = 1'b0;
        cfg_write    = 1'b0;
    endtask

    task automatic drive_sample(input logic [`DATA_W-1:0] data, input logic listed,
                                input zone_t expected);
        @(posedge clk);
        #1;
        sample_valid = 1'b1;
        sample_data  = data;
        table_valid  = listed;
        table_zone   = expected;
        cfg_write    = 1'b0;
    endtask

    task automatic drive_config(input cfg_op_t op, input logic [`DATA_W-1:0] data);
        @(posedge clk);
        #1;
        sample_valid = 1'b0;
        cfg_write    = 1'b1;
        cfg_op       = op;
        cfg_data     = data;
    endtask

    task automatic build_table();
        add_row(KIND_SAMPLE, 8'h40, OP_SET_LOWER, ZONE_INSIDE, 0); // Edges of the reset window.
        add_row(KIND_SAMPLE, 8'hC0, OP_SET_LOWER, ZONE_INSIDE, 0);
        add_row(KIND_SAMPLE, 8'h3F, OP_SET_LOWER, ZONE_BELOW, 0);
        add_row(KIND_SAMPLE, 8'hC1, OP_SET_LOWER, ZONE_ABOVE, 3);
        add_row(KIND_SAMPLE, 8'h50, OP_SET_LOWER, ZONE_INSIDE, 0); // Limit write between two samples.
        add_row(KIND_CONFIG, 8'h60, OP_SET_LOWER, ZONE_INSIDE, 0);
        add_row(KIND_SAMPLE, 8'h50, OP_SET_LOWER, ZONE_BELOW, 2);
        add_row(KIND_CONFIG, 8'hD0, OP_SET_LOWER, ZONE_INSIDE, 0); // Empty window.
        add_row(KIND_CONFIG, 8'h30, OP_SET_UPPER, ZONE_INSIDE, 0);
        add_row(KIND_SAMPLE, 8'h00, OP_SET_LOWER, ZONE_BELOW, 0);
        add_row(KIND_SAMPLE, 8'h80, OP_SET_LOWER, ZONE_BELOW, 0);
        add_row(KIND_SAMPLE, 8'hFF, OP_SET_LOWER, ZONE_ABOVE, 0);
        add_row(KIND_SAMPLE, 8'hD0, OP_SET_LOWER, ZONE_ABOVE, 3);
        add_row(KIND_CONFIG, 8'h40, OP_SET_LOWER, ZONE_INSIDE, 0);
        add_row(KIND_CONFIG, 8'hC0, OP_SET_UPPER, ZONE_INSIDE, 0);
        add_row(KIND_CONFIG, 8'h03, OP_SET_PERSIST, ZONE_INSIDE, 0);
        add_row(KIND_CONFIG, 8'h00, OP_CLEAR_COUNTS, ZONE_INSIDE, 0);
        add_row(KIND_SAMPLE, 8'h80, OP_SET_LOWER, ZONE_INSIDE, 0);
        add_row(KIND_SAMPLE, 8'h80, OP_SET_LOWER, ZONE_INSIDE, 0);
        add_row(KIND_SAMPLE, 8'h80, OP_SET_LOWER, ZONE_INSIDE, 2);
        add_row(KIND_SAMPLE, 8'h10, OP_SET_LOWER, ZONE_BELOW, 0); // Two outliers raise no alarm.
        add_row(KIND_SAMPLE, 8'hF0, OP_SET_LOWER, ZONE_ABOVE, 0);
        add_row(KIND_SAMPLE, 8'h80, OP_SET_LOWER, ZONE_INSIDE, 1);
        add_row(KIND_SAMPLE, 8'h10, OP_SET_LOWER, ZONE_BELOW, 0); // Three outliers raise it.
        add_row(KIND_SAMPLE, 8'h20, OP_SET_LOWER, ZONE_BELOW, 0);
        add_row(KIND_SAMPLE, 8'hF0, OP_SET_LOWER, ZONE_ABOVE, 1);
        add_row(KIND_SAMPLE, 8'h80, OP_SET_LOWER, ZONE_INSIDE, 0);
        add_row(KIND_SAMPLE, 8'h05, OP_SET_LOWER, ZONE_BELOW, 1); // Relapse during recovery.
        add_row(KIND_SAMPLE, 8'h80, OP_SET_LOWER, ZONE_INSIDE, 0);
        add_row(KIND_SAMPLE, 8'h90, OP_SET_LOWER, ZONE_INSIDE, 0);
        add_row(KIND_SAMPLE, 8'hA0, OP_SET_LOWER, ZONE_INSIDE, 2);
        add_row(KIND_CONFIG, 8'h00, OP_SET_PERSIST, ZONE_INSIDE, 0);
        add_row(KIND_SAMPLE, 8'h01, OP_SET_LOWER, ZONE_BELOW, 2);
        add_row(KIND_SAMPLE, 8'h80, OP_SET_LOWER, ZONE_INSIDE, 2);
        add_row(KIND_CONFIG, 8'hF3, OP_SET_PERSIST, ZONE_INSIDE, 0); // Upper bits dropped.
        add_row(KIND_SAMPLE, 8'hFE, OP_SET_LOWER, ZONE_ABOVE, 0); // Clear meets an increment.
        add_row(KIND_CONFIG, 8'h00, OP_CLEAR_COUNTS, ZONE_INSIDE, 4);
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (pending != 0 && waited < `COMPARE_STAGES + 10) begin
            @(posedge clk);
            waited++;
        end
        if (pending != 0) begin
            drain_errors++;
            $display("Timeout: %0d samples still had no zone_valid at end of run", pending);
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        sample_valid = 1'b0;
        sample_data  = '0;
        table_valid  = 1'b0;
        table_zone   = ZONE_INSIDE;
        cfg_write    = 1'b0;
        cfg_op       = OP_SET_LOWER;
        cfg_data     = '0;
        drain_errors = 0;
        rand_state   = 32'h24e0;
        build_table();
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        foreach (rows[i]) begin
            if (rows[i].kind == KIND_SAMPLE) begin
                drive_sample(rows[i].data, 1'b1, rows[i].zone);
            end else begin
                drive_config(rows[i].op, rows[i].data);
            end
            repeat (rows[i].gap) drive_idle();
        end
        for (int n = 0; n < 200; n++) begin
            if (n % 40 == 0) begin
                rand_state = xorshift(rand_state);
                drive_config(OP_SET_LOWER, rand_state[7:0]);
                drive_config(OP_SET_UPPER, rand_state[15:8] | 8'h40);
                drive_config(OP_SET_PERSIST, rand_state[23:16]);
            end
            rand_state = xorshift(rand_state);
            drive_sample(rand_state[7:0], 1'b0, ZONE_INSIDE);
            repeat (rand_state[9:8]) drive_idle();
        end
        drive_idle();
        wait_for_drain();
        repeat (4) @(posedge clk);
        $display("Errors: %0d mismatches, %0d zone timeouts, %0d drain timeouts",
                 mismatch_count, timeout_count, drain_errors);
        if (mismatch_count + timeout_count + drain_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+design
design/window_monitor_pkg.sv
design/limit_config.sv
design/range_compare.sv
design/persistence_filter.sv
design/excursion_counter.sv
design/window_monitor_top.sv
verification/window_monitor_checker.sv
verification/window_monitor_tb.sv
